// File: logic/dp_link_pkg.sv
package dp_link_pkg;

    localparam int LANES_MAX = 4;
    localparam int SPL       = 2;   // Symbols per lane per clock

    // DP link symbols, data in the low byte
    typedef struct packed {
        logic       disp_ctl;   // 0 automatic, 1 forced
        logic       disp_val;   // 0 negative, 1 positive
        logic       k;
        logic [7:0] data;
    } dp_tx_sym_t;

    typedef struct packed {
        logic       k;
        logic [7:0] data;
    } dp_rx_sym_t;

    typedef dp_tx_sym_t [SPL-1:0] dp_tx_lane_t;    // Symbol 0 low
    typedef dp_rx_sym_t [SPL-1:0] dp_rx_lane_t;

    // Transceiver parallel lanes
    typedef struct packed {
        logic [SPL-1:0]   disp_ctl;
        logic [SPL-1:0]   disp_val;
        logic [SPL-1:0]   k;
        logic [8*SPL-1:0] data;
    } phy_tx_lane_t;

    typedef struct packed {
        logic [SPL-1:0]   k;
        logic [8*SPL-1:0] data;
    } phy_rx_lane_t;

    typedef logic [LANES_MAX-1:0][1:0] lane_map_t;

    // Entry 0 in the low bits
    localparam lane_map_t TX_LANE_MAP = {2'd3, 2'd2, 2'd0, 2'd1};  // Source DP lane per PHY lane
    localparam lane_map_t RX_LANE_MAP = {2'd1, 2'd0, 2'd2, 2'd3};  // Source PHY lane per DP lane

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0]  REG_ID   = 8'h00;
    localparam logic [7:0]  REG_CTL  = 8'h04;
    localparam logic [7:0]  REG_STS  = 8'h08;
    localparam logic [31:0] ID_VALUE = {16'h0000, 8'd1, 8'd0};    // Major, minor

    // PLL power-down sits in bit 0
    typedef struct packed {
        logic clk_sel;
        logic rx_drst;
        logic rx_arst;
        logic tx_drst;
        logic tx_arst;
        logic pll_pwrdwn;
    } phy_ctl_t;

    localparam phy_ctl_t PHY_CTL_RST = '{clk_sel: 1'b0, default: 1'b1};

    typedef struct packed {
        logic [LANES_MAX-1:0] cdr_lock;
        logic [LANES_MAX-1:0] rx_cal_busy;
        logic [LANES_MAX-1:0] tx_cal_busy;
        logic                 pll_locked;
        logic                 pll_cal_busy;
    } phy_sts_t;

endpackage

// File: logic/dp_rst_seq.sv
`timescale 1ns/10ps

module dp_rst_seq
#(
    parameter int RST_CYCLES = 1024
)
(
    input  logic CLK_IN,
    input  logic arst_n,
    input  logic pll_lock,
    output logic sys_rst_n
);

    localparam int CNT_W = $clog2(RST_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    // Counter saturates at RST_CYCLES and restarts whenever lock drops
    always_ff @(posedge CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt       <= '0;
            sys_rst_n <= 1'b0;
        end
        else if (!pll_lock)
        begin
            cnt       <= '0;
            sys_rst_n <= 1'b0;      // Back into reset at once
        end
        else
        begin
            if (cnt != CNT_W'(RST_CYCLES))
                cnt <= cnt + 1'b1;

            // Release on the edge that brings the count to RST_CYCLES
            if (cnt >= CNT_W'(RST_CYCLES - 1))
                sys_rst_n <= 1'b1;
        end
    end

    // Release only ever follows a sampled lock
    a_rise_needs_lock: assert property (
        @(posedge CLK_IN) disable iff (!arst_n)
        $rose(sys_rst_n) |-> $past(pll_lock)
    );

endmodule

// File: logic/dp_lane_map.sv
`timescale 1ns/10ps

module dp_lane_map
#(
    parameter type                    lane_t = logic,
    parameter int                     LANES  = dp_link_pkg::LANES_MAX,
    parameter dp_link_pkg::lane_map_t MAP    = dp_link_pkg::TX_LANE_MAP
)
(
    input  logic  CLK_IN,
    input  logic  arst_n,
    input  logic  clr,
    input  lane_t lanes_in  [LANES],
    output lane_t lanes_out [LANES]
);

    // One register stage, output lane p takes input lane MAP[p]
    always_ff @(posedge CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int p = 0; p < LANES; p++)
                lanes_out[p] <= '0;
        end
        else if (clr)
        begin
            for (int p = 0; p < LANES; p++)
                lanes_out[p] <= '0;     // Digital reset from the PHY control
        end
        else
        begin
            for (int p = 0; p < LANES; p++)
                lanes_out[p] <= lanes_in[MAP[p]];
        end
    end

    for (genvar p = 0; p < LANES; p++)
    begin : g_chk
        a_clr_zero: assert property (
            @(posedge CLK_IN) disable iff (!arst_n)
            clr |=> (lanes_out[p] == '0)
        );
    end

endmodule

// File: logic/dp_tx_phy_pack.sv
`timescale 1ns/10ps

module dp_tx_phy_pack
#(
    parameter int                     LANES = dp_link_pkg::LANES_MAX,
    parameter dp_link_pkg::lane_map_t MAP   = dp_link_pkg::TX_LANE_MAP
)
(
    input  logic                      CLK_IN,
    input  logic                      arst_n,
    input  logic                      clr,
    input  dp_link_pkg::dp_tx_lane_t  dp_tx  [LANES],
    output dp_link_pkg::phy_tx_lane_t phy_tx [LANES]
);

    dp_link_pkg::dp_tx_lane_t dp_tx_inv [LANES];
    dp_link_pkg::dp_tx_lane_t mapped    [LANES];

    // Transceiver takes disparity value in the opposite sense.
    // Inverting ahead of the register keeps a cleared lane all zero.
    always_comb
    begin
        for (int p = 0; p < LANES; p++)
        begin
            dp_tx_inv[p] = dp_tx[p];
            for (int s = 0; s < dp_link_pkg::SPL; s++)
                dp_tx_inv[p][s].disp_val = ~dp_tx[p][s].disp_val;
        end
    end

    dp_lane_map
    #(
        .lane_t (dp_link_pkg::dp_tx_lane_t),
        .LANES  (LANES),
        .MAP    (MAP)
    )
    u_tx_map
    (
        .CLK_IN    (CLK_IN),
        .arst_n    (arst_n),
        .clr       (clr),
        .lanes_in  (dp_tx_inv),
        .lanes_out (mapped)
    );

    // Symbol s goes to byte s and bit s of each PHY field
    always_comb
    begin
        for (int p = 0; p < LANES; p++)
        begin
            for (int s = 0; s < dp_link_pkg::SPL; s++)
            begin
                phy_tx[p].data[8*s +: 8] = mapped[p][s].data;
                phy_tx[p].k[s]           = mapped[p][s].k;
                phy_tx[p].disp_val[s]    = mapped[p][s].disp_val;
                phy_tx[p].disp_ctl[s]    = mapped[p][s].disp_ctl;
            end
        end
    end

endmodule

// File: logic/dp_phy_ctl_regs.sv
`timescale 1ns/10ps

module dp_phy_ctl_regs
(
    input  logic                  CLK_IN,
    input  logic                  arst_n,
    input  logic                  sys_rst_n,
    input  dp_link_pkg::apb_req_t apb_req,
    output dp_link_pkg::apb_rsp_t apb_rsp,
    input  dp_link_pkg::phy_sts_t phy_sts,
    output dp_link_pkg::phy_ctl_t phy_ctl
);

    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    logic [31:0]           sts_word;
    logic [31:0]           rd_data;
    dp_link_pkg::phy_ctl_t ctl_q;

    // Single-cycle access phase, no wait states
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite && sys_rst_n;
    assign rd_en  = access && !apb_req.pwrite && sys_rst_n;

    always_ff @(posedge CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
            ctl_q <= dp_link_pkg::PHY_CTL_RST;
        else if (!sys_rst_n)
            ctl_q <= dp_link_pkg::PHY_CTL_RST;     // Start from reset value on release
        else if (wr_en && (apb_req.paddr == dp_link_pkg::REG_CTL))
            ctl_q <= dp_link_pkg::phy_ctl_t'(apb_req.pwdata[5:0]);
    end

    // Hold the PHY in reset for as long as the system is
    assign phy_ctl = sys_rst_n ? ctl_q : dp_link_pkg::PHY_CTL_RST;

    // Per-lane status collapsed to one bit each
    assign sts_word = {
        27'd0,
        &phy_sts.cdr_lock,
        |phy_sts.rx_cal_busy,
        |phy_sts.tx_cal_busy,
        phy_sts.pll_locked,
        phy_sts.pll_cal_busy
    };

    always_comb
    begin
        case (apb_req.paddr)
            dp_link_pkg::REG_ID:  rd_data = dp_link_pkg::ID_VALUE;
            dp_link_pkg::REG_CTL: rd_data = {26'd0, ctl_q};
            dp_link_pkg::REG_STS: rd_data = sts_word;
            default:              rd_data = 32'd0;    // Unmapped
        endcase
    end

    always_comb
    begin
        apb_rsp.prdata  = rd_en ? rd_data : 32'd0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !sys_rst_n;    // Bus error while held in reset
    end

    a_penable_after_psel: assert property (
        @(posedge CLK_IN) disable iff (!arst_n)
        apb_req.penable |-> $past(apb_req.psel)
    );

    // Reset value also holds on the first cycle after release
    a_ctl_in_reset: assert property (
        @(posedge CLK_IN) disable iff (!arst_n)
        (!sys_rst_n || $rose(sys_rst_n)) |-> (phy_ctl == dp_link_pkg::PHY_CTL_RST)
    );

endmodule

// File: logic/dp_link_bridge_top.sv
`timescale 1ns/10ps

module dp_link_bridge_top
#(
    parameter int                     LANES       = dp_link_pkg::LANES_MAX,
    parameter int                     RST_CYCLES  = 1024,
    parameter dp_link_pkg::lane_map_t TX_LANE_MAP = dp_link_pkg::TX_LANE_MAP,
    parameter dp_link_pkg::lane_map_t RX_LANE_MAP = dp_link_pkg::RX_LANE_MAP
)
(
    input  logic                      CLK_IN,
    input  logic                      arst_n,
    input  logic                      pll_lock,

    // Register access
    input  dp_link_pkg::apb_req_t     apb_req,
    output dp_link_pkg::apb_rsp_t     apb_rsp,

    // PHY control and status
    input  dp_link_pkg::phy_sts_t     phy_sts,
    output dp_link_pkg::phy_ctl_t     phy_ctl,

    // TX link
    input  dp_link_pkg::dp_tx_lane_t  dp_tx  [LANES],
    output dp_link_pkg::phy_tx_lane_t phy_tx [LANES],

    // RX link
    input  dp_link_pkg::phy_rx_lane_t phy_rx [LANES],
    output dp_link_pkg::dp_rx_lane_t  dp_rx  [LANES]
);

    logic                          sys_rst_n;
    wire dp_link_pkg::dp_rx_lane_t phy_rx_sym [LANES];

    dp_rst_seq
    #(
        .RST_CYCLES (RST_CYCLES)
    )
    u_rst_seq
    (
        .CLK_IN    (CLK_IN),
        .arst_n    (arst_n),
        .pll_lock  (pll_lock),
        .sys_rst_n (sys_rst_n)
    );

    dp_phy_ctl_regs u_regs
    (
        .CLK_IN    (CLK_IN),
        .arst_n    (arst_n),
        .sys_rst_n (sys_rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .phy_sts   (phy_sts),
        .phy_ctl   (phy_ctl)
    );

    dp_tx_phy_pack
    #(
        .LANES (LANES),
        .MAP   (TX_LANE_MAP)
    )
    u_tx_pack
    (
        .CLK_IN (CLK_IN),
        .arst_n (arst_n),
        .clr    (phy_ctl.tx_drst),
        .dp_tx  (dp_tx),
        .phy_tx (phy_tx)
    );

    // Split each PHY lane into symbols, low byte is symbol 0
    for (genvar p = 0; p < LANES; p++)
    begin : g_rx_lane
        for (genvar s = 0; s < dp_link_pkg::SPL; s++)
        begin : g_rx_sym
            assign phy_rx_sym[p][s] = {phy_rx[p].k[s], phy_rx[p].data[8*s +: 8]};
        end
    end

    dp_lane_map
    #(
        .lane_t (dp_link_pkg::dp_rx_lane_t),
        .LANES  (LANES),
        .MAP    (RX_LANE_MAP)
    )
    u_rx_map
    (
        .CLK_IN    (CLK_IN),
        .arst_n    (arst_n),
        .clr       (phy_ctl.rx_drst),
        .lanes_in  (phy_rx_sym),
        .lanes_out (dp_rx)
    );

endmodule

// File: bench/tb_dp_link_bridge.sv
`timescale 1ns/10ps

module tb_dp_link_bridge;

    localparam int LANES       = dp_link_pkg::LANES_MAX;
    localparam int RST_CYCLES  = 16;
    localparam int STREAM_LEN  = 200;   // Words per streaming burst
    localparam int MAX_CYCLES  = 2000;  // Several times the full sequence

    logic                      CLK_IN = 1'b0;
    logic                      arst_n;
    logic                      pll_lock;
    dp_link_pkg::apb_req_t     apb_req;
    dp_link_pkg::apb_rsp_t     apb_rsp;
    dp_link_pkg::phy_sts_t     phy_sts;
    dp_link_pkg::phy_ctl_t     phy_ctl;
    dp_link_pkg::dp_tx_lane_t  dp_tx  [LANES];
    dp_link_pkg::phy_tx_lane_t phy_tx [LANES];
    dp_link_pkg::phy_rx_lane_t phy_rx [LANES];
    dp_link_pkg::dp_rx_lane_t  dp_rx  [LANES];

    // Reference model state
    int                        lock_cnt;
    logic                      exp_up;
    dp_link_pkg::phy_ctl_t     exp_ctl_q;
    dp_link_pkg::phy_ctl_t     exp_phy_ctl;
    logic [31:0]               exp_rdata;
    dp_link_pkg::phy_tx_lane_t exp_phy_tx [LANES];
    dp_link_pkg::dp_rx_lane_t  exp_dp_rx  [LANES];
    logic                      apb_access_phase;

    int seed      = 2;
    int cycle_cnt = 0;

    always #20 CLK_IN = ~CLK_IN;

    dp_link_bridge_top
    #(
        .LANES       (LANES),
        .RST_CYCLES  (RST_CYCLES),
        .TX_LANE_MAP (dp_link_pkg::TX_LANE_MAP),
        .RX_LANE_MAP (dp_link_pkg::RX_LANE_MAP)
    )
    uut
    (
        .CLK_IN   (CLK_IN),
        .arst_n   (arst_n),
        .pll_lock (pll_lock),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .phy_sts  (phy_sts),
        .phy_ctl  (phy_ctl),
        .dp_tx    (dp_tx),
        .phy_tx   (phy_tx),
        .phy_rx   (phy_rx),
        .dp_rx    (dp_rx)
    );

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped");
    endtask

    // PHY field layout, symbol 0 low, transceiver disparity sense inverted
    function automatic dp_link_pkg::phy_tx_lane_t pack_tx_lane(dp_link_pkg::dp_tx_lane_t src);
        dp_link_pkg::phy_tx_lane_t res;
        for (int s = 0; s < dp_link_pkg::SPL; s++)
        begin
            res.data[8*s +: 8] = src[s].data;
            res.k[s]           = src[s].k;
            res.disp_val[s]    = !src[s].disp_val;
            res.disp_ctl[s]    = src[s].disp_ctl;
        end
        return res;
    endfunction

    function automatic dp_link_pkg::dp_rx_lane_t split_rx_lane(dp_link_pkg::phy_rx_lane_t src);
        dp_link_pkg::dp_rx_lane_t res;
        for (int s = 0; s < dp_link_pkg::SPL; s++)
        begin
            res[s].data = src.data[8*s +: 8];
            res[s].k    = src.k[s];
        end
        return res;
    endfunction

    // System reset released after RST_CYCLES edges that sample lock high
    always_ff @(posedge CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lock_cnt <= 0;
            exp_up   <= 1'b0;
        end
        else if (!pll_lock)
        begin
            lock_cnt <= 0;
            exp_up   <= 1'b0;
        end
        else
        begin
            if (lock_cnt < RST_CYCLES)
                lock_cnt <= lock_cnt + 1;
            if (lock_cnt + 1 >= RST_CYCLES)
                exp_up <= 1'b1;
        end
    end

    assign apb_access_phase = apb_req.psel && apb_req.penable;

    always_ff @(posedge CLK_IN or negedge arst_n)
    begin
        if (!arst_n)
            exp_ctl_q <= dp_link_pkg::PHY_CTL_RST;
        else if (!exp_up)
            exp_ctl_q <= dp_link_pkg::PHY_CTL_RST;
        else if (apb_access_phase && apb_req.pwrite && apb_req.paddr == dp_link_pkg::REG_CTL)
            exp_ctl_q <= apb_req.pwdata[5:0];
    end

    assign exp_phy_ctl = exp_up ? exp_ctl_q : dp_link_pkg::PHY_CTL_RST;

    always_comb
    begin
        exp_rdata = 32'd0;
        if (exp_up)
        begin
            if (apb_req.paddr == dp_link_pkg::REG_ID)
                exp_rdata = {16'd0, 8'd1, 8'd0};    // Version 1.0
            else if (apb_req.paddr == dp_link_pkg::REG_CTL)
                exp_rdata[5:0] = exp_ctl_q;
            else if (apb_req.paddr == dp_link_pkg::REG_STS)
            begin
                exp_rdata[0] = phy_sts.pll_cal_busy;
                exp_rdata[1] = phy_sts.pll_locked;
                exp_rdata[2] = |phy_sts.tx_cal_busy;
                exp_rdata[3] = |phy_sts.rx_cal_busy;
                exp_rdata[4] = &phy_sts.cdr_lock;
            end
        end
    end

    // One-word delay on each link path
    always_ff @(posedge CLK_IN or negedge arst_n)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            if (!arst_n || exp_phy_ctl.tx_drst)
                exp_phy_tx[i] <= '0;
            else
                exp_phy_tx[i] <= pack_tx_lane(dp_tx[dp_link_pkg::TX_LANE_MAP[i]]);
            if (!arst_n || exp_phy_ctl.rx_drst)
                exp_dp_rx[i] <= '0;
            else
                exp_dp_rx[i] <= split_rx_lane(phy_rx[dp_link_pkg::RX_LANE_MAP[i]]);
        end
    end

    a_phy_ctl: assert property (
        @(posedge CLK_IN) disable iff (!arst_n) phy_ctl == exp_phy_ctl
    ) else stop_on_failure($sformatf("CHECK FAILED at %t: phy_ctl is %h, expected %h",
                                     $time, phy_ctl, exp_phy_ctl));

    a_pready: assert property (@(posedge CLK_IN) apb_access_phase |-> apb_rsp.pready)
        else stop_on_failure($sformatf("CHECK FAILED at %t: pready low", $time));

    a_pslverr: assert property (
        @(posedge CLK_IN) apb_access_phase |-> (apb_rsp.pslverr == !exp_up)
    ) else stop_on_failure($sformatf("CHECK FAILED at %t: pslverr is %b",
                                     $time, apb_rsp.pslverr));

    a_prdata: assert property (
        @(posedge CLK_IN) (apb_access_phase && !apb_req.pwrite) |-> (apb_rsp.prdata == exp_rdata)
    ) else stop_on_failure($sformatf("CHECK FAILED at %t: read %h from %h, expected %h",
                                     $time, apb_rsp.prdata, apb_req.paddr, exp_rdata));

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane_chk
        a_phy_tx: assert property (
            @(posedge CLK_IN) disable iff (!arst_n) phy_tx[i] == exp_phy_tx[i]
        ) else stop_on_failure($sformatf("CHECK FAILED at %t: phy_tx lane %0d is %h, expected %h",
                                         $time, i, phy_tx[i], exp_phy_tx[i]));
        a_dp_rx: assert property (
            @(posedge CLK_IN) disable iff (!arst_n) dp_rx[i] == exp_dp_rx[i]
        ) else stop_on_failure($sformatf("CHECK FAILED at %t: dp_rx lane %0d is %h, expected %h",
                                         $time, i, dp_rx[i], exp_dp_rx[i]));
    end

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(posedge CLK_IN);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(posedge CLK_IN);
        apb_req.penable <= 1'b1;    // Access phase
        @(posedge CLK_IN);
        apb_req <= '0;
    endtask

    task automatic set_lane_clear(input logic tx_clr, input logic rx_clr);
        dp_link_pkg::phy_ctl_t ctl;
        ctl         = dp_link_pkg::PHY_CTL_RST;
        ctl.tx_drst = tx_clr;
        ctl.rx_drst = rx_clr;
        apb_access(1'b1, dp_link_pkg::REG_CTL, {26'd0, ctl});
    endtask

    task automatic stream_lanes(input int cycles);
        logic [31:0] rnd;
        repeat (cycles)
        begin
            @(posedge CLK_IN);
            for (int i = 0; i < LANES; i++)
            begin
                rnd = $random(seed);
                dp_tx[i] <= dp_link_pkg::dp_tx_lane_t'(rnd[21:0]);
                rnd = $random(seed);
                phy_rx[i] <= dp_link_pkg::phy_rx_lane_t'(rnd[17:0]);
            end
        end
    endtask

    always @(posedge CLK_IN) cycle_cnt <= cycle_cnt + 1;

    initial
    begin
        wait (cycle_cnt >= MAX_CYCLES);
        stop_on_failure($sformatf("Timeout: test still running after %0d clock cycles",
                                  MAX_CYCLES));
    end

    initial
    begin
        logic [31:0] rnd;
        $timeformat(-9, 0, " ns", 0);
        arst_n   = 1'b0;
        pll_lock = 1'b0;
        apb_req  = '0;
        phy_sts  = '0;
        for (int i = 0; i < LANES; i++)
        begin
            dp_tx[i]  = '0;
            phy_rx[i] = '0;
        end
        repeat (8) @(posedge CLK_IN);
        arst_n <= 1'b1;

        // No lock yet, bus errors expected
        apb_access(1'b0, dp_link_pkg::REG_ID, 32'd0);
        apb_access(1'b1, dp_link_pkg::REG_CTL, 32'h0000_0000);
        @(posedge CLK_IN);
        pll_lock <= 1'b1;
        repeat (RST_CYCLES) @(posedge CLK_IN);

        apb_access(1'b0, dp_link_pkg::REG_ID, 32'd0);
        for (int n = 0; n < 4; n++)
        begin
            rnd = $random(seed);
            apb_access(1'b1, dp_link_pkg::REG_CTL, {26'd0, rnd[5:0]});
            apb_access(1'b0, dp_link_pkg::REG_CTL, 32'd0);
            rnd = $random(seed);
            @(posedge CLK_IN);
            phy_sts <= dp_link_pkg::phy_sts_t'(rnd[13:0]);
            apb_access(1'b0, dp_link_pkg::REG_STS, 32'd0);
        end
        // All lanes locked and idle, rare in random status
        @(posedge CLK_IN);
        phy_sts <= '{cdr_lock: '1, default: '0};
        apb_access(1'b0, dp_link_pkg::REG_STS, 32'd0);
        apb_access(1'b1, 8'h0C, 32'hFFFF_FFFF);     // Unmapped, write dropped
        apb_access(1'b0, 8'h0C, 32'd0);
        apb_access(1'b0, 8'h40, 32'd0);
        apb_access(1'b0, dp_link_pkg::REG_CTL, 32'd0);

        // Link paths open, then held in clear, then open again
        set_lane_clear(1'b0, 1'b0);
        stream_lanes(STREAM_LEN);
        set_lane_clear(1'b1, 1'b1);
        stream_lanes(STREAM_LEN / 4);
        set_lane_clear(1'b0, 1'b0);
        stream_lanes(STREAM_LEN / 4);

        @(posedge CLK_IN);
        pll_lock <= 1'b0;
        apb_access(1'b0, dp_link_pkg::REG_CTL, 32'd0);
        stream_lanes(8);
        repeat (4) @(posedge CLK_IN);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: vlog.f
logic/dp_link_pkg.sv
logic/dp_rst_seq.sv
logic/dp_lane_map.sv
logic/dp_tx_phy_pack.sv
logic/dp_phy_ctl_regs.sv
logic/dp_link_bridge_top.sv
bench/tb_dp_link_bridge.sv

// File: Bender.yml
package:
  name: dp_link_bridge

sources:
  - logic/dp_link_pkg.sv
  - logic/dp_rst_seq.sv
  - logic/dp_lane_map.sv
  - logic/dp_tx_phy_pack.sv
  - logic/dp_phy_ctl_regs.sv
  - logic/dp_link_bridge_top.sv
  - target: test
    files:
      - bench/tb_dp_link_bridge.sv
